/* recip_nr_top.f */
hdl/recip_pkg.sv
hdl/recip_seed_lut.sv
hdl/align_delay.sv
hdl/ufix_mult_pipe.sv
hdl/recip_nr_step.sv
hdl/recip_round.sv
hdl/recip_nr_top.sv
tests/clk_gen.sv
tests/recip_assert.sv
tests/recip_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = recip_tb
FLIST     = recip_nr_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Passes only when the simulation printed the pass line
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q ">>> PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/recip_tb.sv */
`timescale 1ns/1ps

module recip_tb;

	import recip_pkg::*;

	//==============================
	// Run length
	//==============================
	localparam int RST_CYCLES = 5;                  // Same as clk_gen
	localparam int N_STREAM   = 300;                // Random inputs with CE high
	localparam int N_STALL    = 400;                // Cycles with random CE
	localparam int LUT_SIZE   = 2 ** LUT_ADDR_W;    // Table segments
	localparam int N_CORNER   = LATENCY + 2 + 2 * LUT_SIZE;  // 1.0 run, all ones, edges
	// Reset and idle and four flushes, then stream, replay, stalls and corners
	localparam int N_STIM = RST_CYCLES + 1 + 5 * LATENCY + 2 * N_STREAM + N_STALL + N_CORNER;
	localparam int MAX_CYCLES = N_STIM + 2 * LATENCY + 100;

	localparam din_t  X_ONE       = 24'h800000;     // 1.0 in 1.23
	localparam dout_t X_ONE_RECIP = 24'h800000;     // y1 is 0.375 LSB under 1.0 and rounds up

	logic  CLK;
	logic  nRST;
	logic  CE;                                      // Driven on falling edge
	din_t  din;
	dout_t dout;

	dout_t exp_q [$];                               // One per register stage with dout in front
	din_t  in_q [$];                                // Source x per stage where zero is a bubble
	din_t  stream_in [N_STREAM];                    // Kept for the bound replay
	dout_t last_dout;                               // dout at previous falling edge
	bit    bound_on = 1'b0;                         // Also check against exact 1/x
	int    cycle_cnt = 0;

	clk_gen u_clk (
		.CLK  (CLK),
		.nRST (nRST)
	);

	recip_nr_top dut (
		.CLK  (CLK),
		.nRST (nRST),
		.CE   (CE),
		.din  (din),
		.dout (dout)
	);

	//==============================
	// Golden model
	//==============================
	// Seed lookup, x*y0 kept in 1.25, complement, product in 2.39, round half up
	function automatic dout_t golden_recip(input din_t x);
		seed_t                y0;
		logic [WL+SEED_W-1:0] xy;                   // x*y0 in 2.37
		err_t                 e_n;                  // About 2 - x*y0
		prod_t                y1;                   // 2.39
		logic [WLO:0]         r;                    // Rounded sum with carry
		y0  = seed_entry(32'(x[WL-2 -: LUT_ADDR_W]));
		xy  = (WL+SEED_W)'(x) * (WL+SEED_W)'(y0);
		e_n = ~xy[WL+SEED_W-2 -: ERR_W];            // 2s bit dropped to leave 26 bits
		y1  = PROD_W'(e_n) * PROD_W'(y0);
		r   = (WLO+1)'(y1[PROD_W-2 -: WLO]) + (WLO+1)'(y1[ROUND_DROP-1]);
		if (r[WLO] || y1[PROD_W-1]) begin
			return '1;                              // 2.0 or more saturates
		end else begin
			return r[WLO-1:0];
		end
	endfunction

	function automatic din_t random_mantissa();
		return {1'b1, 23'($urandom)};               // Hidden one always set
	endfunction

	// Pipeline contents follow CE edges and reset fills them with zeros
	always @(posedge CLK) begin
		if (!nRST) begin
			exp_q.delete();
			in_q.delete();
			for (int i = 0; i < LATENCY; i++) begin
				exp_q.push_back('0);
				in_q.push_back('0);
			end
		end else if (CE) begin
			exp_q.push_back(golden_recip(din));
			in_q.push_back(din);
			void'(exp_q.pop_front());               // Old dout leaves
			void'(in_q.pop_front());
		end
	end

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("Timeout, test did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	//==============================
	// Checks
	//==============================
	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_dout(input dout_t got, input dout_t exp, input string name);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Within 4 LSB of the truncated 2^46 / x
	task automatic check_bound(input dout_t got, input din_t x);
		longint unsigned exact;
		longint unsigned diff;
		exact = (64'd1 << 46) / 64'(x);
		if (64'(got) > exact) begin
			diff = 64'(got) - exact;
		end else begin
			diff = exact - 64'(got);
		end
		if (diff > 64'd4) begin
			$display("[ERROR] t=%0t dout: got %h, exact 1/x %h for din %h",
				$time, got, exact[WLO-1:0], x);
			abort_run();
		end
	endtask

	// Check what the last rising edge produced, then drive the next cycle
	task automatic drive_cycle(input logic ce, input din_t x);
		@(negedge CLK);
		if (!CE) begin
			check_dout(dout, last_dout, "dout held with CE low");
		end
		check_dout(dout, exp_q[0], "dout");
		if (bound_on && in_q[0] != '0) begin
			check_bound(dout, in_q[0]);
		end
		last_dout = dout;
		CE        = ce;
		din       = x;
	endtask

	task automatic flush_pipe();
		for (int i = 0; i < LATENCY; i++) begin
			drive_cycle(1'b1, X_ONE);               // Pushes the last item out
		end
	endtask

	//==============================
	// Directed tests
	//==============================
	task automatic reset_zero();
		@(posedge CLK);                             // First reset edge
		while (!nRST) begin
			@(negedge CLK);
			check_dout(dout, '0, "dout in reset");
		end
		last_dout = dout;
		for (int i = 0; i < LATENCY; i++) begin
			drive_cycle(1'b0, X_ONE);               // Idle so nothing enters
			check_dout(dout, '0, "dout after reset");
		end
	endtask

	task automatic stream_random();
		din_t x;
		for (int i = 0; i < N_STREAM; i++) begin
			x            = random_mantissa();
			stream_in[i] = x;
			drive_cycle(1'b1, x);                   // One per cycle
		end
		flush_pipe();
	endtask

	task automatic bound_replay();
		bound_on = 1'b1;
		for (int i = 0; i < N_STREAM; i++) begin
			drive_cycle(1'b1, stream_in[i]);
		end
		flush_pipe();
		bound_on = 1'b0;
	endtask

	task automatic ce_stalls();
		logic ce;
		for (int i = 0; i < N_STALL; i++) begin
			ce = (($urandom % 3) != 0);             // Roughly one stall in three
			drive_cycle(ce, random_mantissa());
		end
		flush_pipe();
	endtask

	task automatic corner_sweep();
		din_t lo;
		din_t hi;
		bound_on = 1'b1;
		for (int i = 0; i <= LATENCY; i++) begin
			drive_cycle(1'b1, X_ONE);
		end
		check_dout(dout, X_ONE_RECIP, "dout for x = 1.0");
		drive_cycle(1'b1, 24'hFFFFFF);              // Largest mantissa
		for (int a = 0; a < LUT_SIZE; a++) begin
			lo = {1'b1, LUT_ADDR_W'(a), 11'h000};   // First x of segment
			hi = {1'b1, LUT_ADDR_W'(a), 11'h7FF};   // Last x of segment
			drive_cycle(1'b1, lo);
			drive_cycle(1'b1, hi);
		end
		flush_pipe();
		bound_on = 1'b0;
	endtask

	initial begin
		CE  = 1'b0;
		din = X_ONE;
		void'($urandom(34));                        // Fixed seed
		reset_zero();
		stream_random();
		bound_replay();
		ce_stalls();
		corner_sweep();
		if (dut.u_chk.fails == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", dut.u_chk.fails);
			abort_run();
		end
	end

endmodule

/* tests/recip_assert.sv */
`timescale 1ns/1ps

module recip_assert (
	input logic             CLK,      // DUT clock
	input logic             nRST,     // DUT reset
	input logic             CE,       // Pipeline advance
	input recip_pkg::dout_t dout      // Rounded reciprocal
);

	int fails = 0;                    // Failure count, read at end of run

	//==============================
	// Output rules
	//==============================
	a_rst_zero: assert property (@(posedge CLK) !nRST |=> dout == '0)
		else begin
			fails++;
			$error("dout not cleared by a reset edge");
		end

	// Every register holds while CE is low
	a_ce_hold: assert property (@(posedge CLK) disable iff (!nRST) !CE |=> $stable(dout))
		else begin
			fails++;
			$error("dout changed in a cycle with CE low");
		end

	a_known: assert property (@(posedge CLK) disable iff (!nRST) !$isunknown(dout))
		else begin
			fails++;
			$error("dout has unknown bits after reset");
		end

endmodule

bind recip_nr_top recip_assert u_chk (
	.CLK  (CLK),
	.nRST (nRST),
	.CE   (CE),
	.dout (dout)
);

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic CLK,                 // 8 ns period
	output logic nRST                 // Low for the first 5 rising edges
);

	localparam int RST_CYCLES = 5;    // Reset length in clock cycles

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;        // 125 MHz
	end

	initial begin
		nRST <= 1'b0;                 // Asserted from time zero
		repeat (RST_CYCLES) @(posedge CLK);
		nRST <= 1'b1;                 // Last reset edge still sees it low
	end

endmodule

/* hdl/recip_nr_top.sv */
`timescale 1ns/1ps

// Mantissa reciprocal, seed table plus one Newton-Raphson step.
// dout holds 1/din six CE edges after din was sampled.
module recip_nr_top (
	input  logic             CLK,    // Clock
	input  logic             nRST,   // Sync reset, active low
	input  logic             CE,     // Pipeline advance, only flow control
	input  recip_pkg::din_t  din,    // x in 1.23, bit 23 set
	output recip_pkg::dout_t dout    // 1/x in 1.23
);

	import recip_pkg::*;

	din_t  x_q;                      // Registered x
	seed_t seed;                     // Table seed y0
	prod_t refined;                  // y1 before rounding

	// Input register and seed lookup
	recip_seed_lut u_lut (
		.CLK  (CLK),
		.nRST (nRST),
		.CE   (CE),
		.din  (din),
		.x_q  (x_q),
		.seed (seed)
	);

	// Error product, complement, refinement
	recip_nr_step u_nr (
		.CLK     (CLK),
		.nRST    (nRST),
		.CE      (CE),
		.x_q     (x_q),
		.seed    (seed),
		.refined (refined)
	);

	// Round into 1.23
	recip_round u_rnd (
		.CLK     (CLK),
		.nRST    (nRST),
		.CE      (CE),
		.refined (refined),
		.dout    (dout)
	);

endmodule

/* hdl/recip_round.sv */
`timescale 1ns/1ps

module recip_round (
	input  logic             CLK,      // Clock
	input  logic             nRST,     // Sync reset, active low
	input  logic             CE,       // Pipeline advance
	input  recip_pkg::prod_t refined,  // y1, 2.39
	output recip_pkg::dout_t dout      // 1/x, 1.23
);

	import recip_pkg::*;

	logic [WLO-1:0] kept;              // Bits 39..16, value in 1.23
	logic           half;              // Bit 15, first dropped bit
	logic [WLO:0]   sum;               // Rounded, with carry
	logic           ovf;               // Result not representable

	//==============================
	// Round half up
	//==============================
	assign kept = refined[PROD_W-2 -: WLO];
	assign half = refined[ROUND_DROP-1];
	assign sum  = {1'b0, kept} + (WLO + 1)'(half);  // Add one at bit 15
	// Carry out or integer bit 1 set means the value is 2.0 or more
	assign ovf  = sum[WLO] | refined[PROD_W-1];

	// Output register
	always_ff @(posedge CLK) begin
		if (!nRST) begin
			dout <= '0;                    // Zero after reset
		end else if (CE) begin
			if (ovf) begin
				dout <= '1;                // Saturate to just under 2
			end else begin
				dout <= sum[WLO-1:0];
			end
		end
	end

endmodule

/* hdl/recip_nr_step.sv */
`timescale 1ns/1ps

// One Newton-Raphson step, y1 = y0 * (2 - x*y0).
// The 2 - e term is the bitwise complement of e in 1.25, off by one LSB.
module recip_nr_step (
	input  logic             CLK,      // Clock
	input  logic             nRST,     // Sync reset, active low
	input  logic             CE,       // Pipeline advance
	input  recip_pkg::din_t  x_q,      // x, 1.23
	input  recip_pkg::seed_t seed,     // y0, 1.14
	output recip_pkg::prod_t refined   // y1, 2.39
);

	import recip_pkg::*;

	err_t  err;                        // x*y0, 1.25
	err_t  err_n;                      // ~(x*y0), about 2 - x*y0
	seed_t seed_d;                     // y0 lined up with err_n

	//==============================
	// Error product
	//==============================
	// x < 2 and y0 < 1, so x*y0 < 2 and the top integer bit is dropped
	ufix_mult_pipe #(
		.A_W    (WL),
		.B_W    (SEED_W),
		.P_W    (ERR_W),
		.STAGES (MUL1_STAGES)
	) u_mul_err (
		.CLK  (CLK),
		.nRST (nRST),
		.CE   (CE),
		.a    (x_q),
		.b    (seed),
		.p    (err)
	);

	// Complement register
	always_ff @(posedge CLK) begin
		if (!nRST) begin
			err_n <= '0;
		end else if (CE) begin
			err_n <= ~err;             // 2 - 2^-25 - x*y0
		end
	end

	// Seed waits for mult1 and the complement register
	align_delay #(
		.DEPTH     (SEED_ALIGN),
		.payload_t (seed_t)
	) u_seed_dly (
		.CLK  (CLK),
		.nRST (nRST),
		.CE   (CE),
		.d    (seed),
		.q    (seed_d)
	);

	//==============================
	// Refinement product
	//==============================
	ufix_mult_pipe #(
		.A_W    (ERR_W),
		.B_W    (SEED_W),
		.P_W    (PROD_W),              // Full width, nothing dropped
		.STAGES (MUL2_STAGES)
	) u_mul_ref (
		.CLK  (CLK),
		.nRST (nRST),
		.CE   (CE),
		.a    (err_n),
		.b    (seed_d),
		.p    (refined)
	);

endmodule

/* hdl/ufix_mult_pipe.sv */
`timescale 1ns/1ps

// Unsigned fixed-point multiply, both operands with one integer bit.
// The full product is 2.(A_W+B_W-2). A narrower output keeps one integer bit,
// so the caller guarantees the product stays below 2. A full-width output keeps both.
module ufix_mult_pipe #(
	parameter int A_W    = 24,               // Operand a width, 1.(A_W-1)
	parameter int B_W    = 15,               // Operand b width, 1.(B_W-1)
	parameter int P_W    = 26,               // Output width, at most A_W+B_W
	parameter int STAGES = 1                 // Output registers, at least one
) (
	input  logic           CLK,              // Clock
	input  logic           nRST,             // Sync reset, active low
	input  logic           CE,               // Pipeline advance
	input  logic [A_W-1:0] a,                // Multiplicand
	input  logic [B_W-1:0] b,                // Multiplier
	output logic [P_W-1:0] p                 // Truncated product, STAGES CE edges later
);

	localparam int FULL_W = A_W + B_W;       // Exact product width
	// MSB kept, top integer bit dropped unless the full word is wanted
	localparam int TOP    = (P_W >= FULL_W) ? FULL_W - 1 : FULL_W - 2;

	logic [FULL_W-1:0] full;                 // Exact product
	logic [P_W-1:0]    trunc;                // Low bits cut off
	logic [P_W-1:0]    pipe [STAGES];        // Product registers

	assign full  = a * b;                    // Both zero extended to FULL_W
	assign trunc = full[TOP -: P_W];         // Truncate, no rounding

	//==============================
	// Product pipeline
	//==============================
	always_ff @(posedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < STAGES; i++) begin
				pipe[i] <= '0;               // Clear all stages
			end
		end else if (CE) begin
			pipe[0] <= trunc;                // First register after the array
			for (int i = 1; i < STAGES; i++) begin
				pipe[i] <= pipe[i-1];        // Retiming stages
			end
		end
	end

	assign p = pipe[STAGES-1];               // Last stage out

endmodule

/* hdl/align_delay.sv */
`timescale 1ns/1ps

module align_delay #(
	parameter int  DEPTH     = 2,     // Stages, at least one
	parameter type payload_t = logic  // Delayed word
) (
	input  logic     CLK,             // Clock
	input  logic     nRST,            // Sync reset, active low
	input  logic     CE,              // Shift enable
	input  payload_t d,               // Word in
	output payload_t q                // Word out, DEPTH CE edges later
);

	payload_t sr [DEPTH];             // Shift stages, sr[0] nearest the input

	always_ff @(posedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < DEPTH; i++) begin
				sr[i] <= payload_t'(0);   // Clear every stage
			end
		end else if (CE) begin
			sr[0] <= d;                   // Load head
			for (int i = 1; i < DEPTH; i++) begin
				sr[i] <= sr[i-1];         // Advance one stage
			end
		end
	end

	assign q = sr[DEPTH-1];           // Tail

endmodule

/* hdl/recip_seed_lut.sv */
`timescale 1ns/1ps

module recip_seed_lut (
	input  logic             CLK,    // Clock
	input  logic             nRST,   // Sync reset, active low
	input  logic             CE,     // Pipeline advance
	input  recip_pkg::din_t  din,    // x in 1.23, bit 23 set
	output recip_pkg::din_t  x_q,    // Registered x
	output recip_pkg::seed_t seed    // y0 for x_q
);

	import recip_pkg::*;

	localparam int LUT_SIZE = 2 ** LUT_ADDR_W;  // 4096 entries

	//==============================
	// Seed table
	//==============================
	seed_t                 lut [LUT_SIZE];      // Constant ROM
	logic [LUT_ADDR_W-1:0] addr;                // Fraction bits under the leading one

	// Each entry is a constant, so this folds into a ROM
	for (genvar i = 0; i < LUT_SIZE; i++) begin : g_lut
		assign lut[i] = seed_entry(i);          // Elaborated seed
	end

	assign addr = din[WL-2 -: LUT_ADDR_W];      // Bits 22..11, hidden one skipped

	//==============================
	// Input register
	//==============================
	always_ff @(posedge CLK) begin
		if (!nRST) begin
			x_q  <= '0;                         // Clear input stage
			seed <= '0;
		end else if (CE) begin
			x_q  <= din;                        // Sample mantissa
			seed <= lut[addr];                  // Seed for the same word
		end
	end

endmodule

/* hdl/recip_pkg.sv */
package recip_pkg;

	//==============================
	// Word formats
	//==============================
	localparam int WL         = 24;               // Input width, 1.23
	localparam int LUT_ADDR_W = 12;               // Fraction bits used as table address
	localparam int SEED_W     = 15;               // Seed width, 1.14
	localparam int ERR_W      = 26;               // Truncated x*y0, 1.25
	localparam int PROD_W     = SEED_W + ERR_W;   // Refinement product, 2.39
	localparam int WLO        = 24;               // Output width, 1.23
	localparam int ROUND_DROP = 16;               // Low bits removed by rounding

	//==============================
	// Pipeline depths
	//==============================
	localparam int MUL1_STAGES = 1;               // Error multiplier registers
	localparam int MUL2_STAGES = 2;               // Refinement multiplier registers
	localparam int SEED_ALIGN  = MUL1_STAGES + 1; // Seed wait, mult1 plus complement reg
	// Input/LUT reg, mult1, complement, mult2, round
	localparam int LATENCY     = 1 + MUL1_STAGES + 1 + MUL2_STAGES + 1;

	//==============================
	// Word types
	//==============================
	typedef logic [WL-1:0]     din_t;             // Normalized mantissa in
	typedef logic [SEED_W-1:0] seed_t;            // Table seed y0
	typedef logic [ERR_W-1:0]  err_t;             // Error term
	typedef logic [PROD_W-1:0] prod_t;            // y0 * ~(x*y0)
	typedef logic [WLO-1:0]    dout_t;            // Rounded reciprocal

	// Seed for table address a
	// Interval [1 + a/4096, 1 + (a+1)/4096) has its midpoint at (8193 + 2a) / 8192,
	// so 1/mid in 1.14 is 2^27 / (8193 + 2a), rounded to nearest
	function automatic seed_t seed_entry(input int unsigned a);
		int unsigned den;
		int unsigned num;
		den = 8193 + 2 * a;                       // Odd, never zero
		num = (32'd1 << 27) + den / 2;            // Half divisor for nearest
		return seed_t'(num / den);                // Top entry 16382, bottom 8193
	endfunction

endpackage
